/* fetch_pc.sv */
`timescale 1ns/10ps

module fetch_pc import fetch_pkg::*; (
    input  logic    clk,
    input  logic    resetn,

    input  logic    redirect,
    input  addr_t   redirect_pc,
    input  logic    line_ok,
    input  qcount_t queue_space,

    output logic    fetch_req,
    output addr_t   fetch_addr,
    output logic    enq_word0,
    output logic    enq_word1,
    output addr_t   enq_base
);

    typedef enum logic [1:0] {
        idle,
        wait_line,
        drop
    } state_t;

    state_t state;
    addr_t  pc;         // next address to fetch
    addr_t  line_base;
    logic   keep_line;

    assign line_base = {fetch_addr[31:3], 3'b000};
    assign fetch_req = (state != idle);
    assign enq_base  = line_base;

    // a redirect in the same cycle flushes the queue, so the line goes too
    assign keep_line = line_ok && (state == wait_line) && !redirect;
    assign enq_word0 = keep_line && !fetch_addr[2];  // entry into word 1 skips word 0
    assign enq_word1 = keep_line;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= idle;
            pc         <= reset_pc;
            fetch_addr <= reset_pc;
        end else begin
            unique case (state)
                idle: begin
                    if (redirect) begin
                        pc <= redirect_pc;
                    end else if (queue_space >= qcount_t'(line_words)) begin
                        fetch_addr <= pc;
                        state      <= wait_line;
                    end
                end
                wait_line: begin
                    if (redirect) begin
                        pc    <= redirect_pc;
                        state <= line_ok ? idle : drop;
                    end else if (line_ok) begin
                        pc    <= line_base + addr_t'(line_bytes);
                        state <= idle;
                    end
                end
                drop: begin
                    if (redirect) begin
                        pc <= redirect_pc;
                    end
                    if (line_ok) begin
                        state <= idle;  // stale line discarded
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] word_t;  // instruction word
    typedef logic [31:0] addr_t;  // virtual or physical byte address

    // branch prediction class carried with each word
    typedef enum logic [1:0] {
        normal    = 2'd0,
        is_branch = 2'd1,
        is_ret    = 2'd2,
        is_call   = 2'd3
    } predecode_t;

    localparam int line_words  = 2;  // words per line, also burst beats
    localparam int queue_depth = 8;
    localparam int word_bytes  = 4;
    localparam int line_bytes  = line_words * word_bytes;

    typedef logic [3:0] qcount_t;                      // 0..queue_depth
    typedef logic [$clog2(queue_depth)-1:0] qptr_t;    // queue slot index
    typedef logic [0:0] beat_t;                        // word within a line

    localparam addr_t reset_pc = 32'hbfc0_0000;  // boot vector in kseg1

    // primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;

    // special function codes
    localparam logic [5:0] funct_jr   = 6'b001000;
    localparam logic [5:0] funct_jalr = 6'b001001;

    // regimm rt codes
    localparam logic [4:0] rt_bltz    = 5'b00000;
    localparam logic [4:0] rt_bgez    = 5'b00001;
    localparam logic [4:0] rt_bltzal  = 5'b10000;
    localparam logic [4:0] rt_bgezal  = 5'b10001;

    localparam logic [4:0] reg_ra     = 5'd31;  // return address register

endpackage

/* icache_fetch.sv */
`timescale 1ns/10ps

module icache_fetch import fetch_pkg::*; (
    input  logic       clk,
    input  logic       resetn,

    input  logic       fetch_req,
    input  addr_t      fetch_addr,
    output logic       line_ok,
    output word_t      line_data0,
    output word_t      line_data1,
    output predecode_t line_class0,
    output predecode_t line_class1,

    output logic       mem_req,
    output addr_t      mem_addr,
    input  logic       mem_ready,
    input  logic       mem_last,
    input  word_t      mem_rdata
);

    addr_t      paddr;
    beat_t      beat;
    word_t      beat_buf  [line_words];
    word_t      next_line [line_words];
    predecode_t next_class0;
    predecode_t next_class1;
    logic       beat_take;
    logic       start_req;
    logic       line_done;

    // kseg0/kseg1 unmapped translation
    always_comb begin
        paddr[27:0] = fetch_addr[27:0];
        unique case (fetch_addr[31:28])
            4'h8, 4'ha: paddr[31:28] = 4'h0;
            4'h9, 4'hb: paddr[31:28] = 4'h1;
            default:    paddr[31:28] = fetch_addr[31:28];
        endcase
    end

    assign beat_take = mem_req && mem_ready;
    assign line_done = beat_take && mem_last;
    // no new burst in the cycle line_ok is up
    assign start_req = !mem_req && fetch_req && !line_ok;

    // line as it will look after this beat
    always_comb begin
        for (int i = 0; i < line_words; i++) begin
            if (beat_take && beat == beat_t'(i)) begin
                next_line[i] = mem_rdata;
            end else begin
                next_line[i] = beat_buf[i];
            end
        end
    end

    predecoder u_pd0 (
        .word (next_line[0]),
        .cls  (next_class0)
    );

    predecoder u_pd1 (
        .word (next_line[1]),
        .cls  (next_class1)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_req <= 1'b0;
            line_ok <= 1'b0;
            beat    <= '0;
        end else begin
            line_ok <= 1'b0;  // single cycle pulse
            if (mem_req) begin
                if (beat_take) begin
                    beat <= beat + 1'b1;
                end
                if (line_done) begin
                    mem_req <= 1'b0;
                    line_ok <= 1'b1;
                    beat    <= '0;
                end
            end else if (start_req) begin
                mem_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            mem_addr <= {paddr[31:3], 3'b000};  // 8 byte aligned
        end
        if (beat_take) begin
            beat_buf[beat] <= mem_rdata;
        end
        if (line_done) begin
            line_data0  <= next_line[0];
            line_data1  <= next_line[1];
            line_class0 <= next_class0;
            line_class1 <= next_class1;
        end
    end

endmodule

/* ifetch_golden.txt */
# m <physical address> <word> <class 0 normal 1 branch 2 return 3 call>
# r <instructions popped before the redirect> <virtual target>
m 1fc00000 3c01bfc0 0
m 1fc00004 10220004 1
m 1fc00008 0c000080 3
m 1fc0000c 00000000 0
m 1fc00010 03e00008 2
m 1fc00014 14220004 1
m 1fc00018 00a00008 0
m 1fc0001c 18200003 1
m 1fc00020 8c220000 0
m 1fc00024 1c200003 1
m 1fc00028 04220005 0
m 1fc0002c 08000040 1
m 00000100 24010001 0
m 00000104 0080f809 1
m 00000108 04200005 1
m 0000010c 00221821 0
m 00000110 04210005 1
m 00000114 03e00008 2
m 00000118 ac220004 0
m 0000011c 00000000 0
m 00000200 04300005 1
m 00000204 34210010 0
m 00000208 04310005 1
m 0000020c 00221825 0
m 00000300 0c000100 3
m 00000304 1c200002 1
m 00000308 24020005 0
m 0000030c 10000003 1
r 3 80000104
r 8 a0000200
r 11 00000300
r 15 9fc00010

/* ifetch_top.sv */
`timescale 1ns/10ps

module ifetch_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       resetn,

    input  logic       redirect,
    input  addr_t      redirect_pc,

    output logic       mem_req,
    output addr_t      mem_addr,
    input  logic       mem_ready,
    input  logic       mem_last,
    input  word_t      mem_rdata,

    output logic       instr_valid,
    output word_t      instr,
    output addr_t      instr_pc,
    output predecode_t instr_class,
    input  logic       instr_ready
);

    logic       fetch_req;
    addr_t      fetch_addr;
    logic       line_ok;
    word_t      line_data0;
    word_t      line_data1;
    predecode_t line_class0;
    predecode_t line_class1;
    logic       enq_word0;
    logic       enq_word1;
    addr_t      enq_base;
    qcount_t    queue_space;

    fetch_pc u_fetch_pc (
        .clk         (clk),
        .resetn      (resetn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .line_ok     (line_ok),
        .queue_space (queue_space),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .enq_word0   (enq_word0),
        .enq_word1   (enq_word1),
        .enq_base    (enq_base)
    );

    icache_fetch u_icache_fetch (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .line_ok     (line_ok),
        .line_data0  (line_data0),
        .line_data1  (line_data1),
        .line_class0 (line_class0),
        .line_class1 (line_class1),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ready   (mem_ready),
        .mem_last    (mem_last),
        .mem_rdata   (mem_rdata)
    );

    instr_queue u_instr_queue (
        .clk         (clk),
        .resetn      (resetn),
        .flush       (redirect),  // old path dropped on redirect
        .enq_word0   (enq_word0),
        .enq_word1   (enq_word1),
        .enq_base    (enq_base),
        .line_data0  (line_data0),
        .line_data1  (line_data1),
        .line_class0 (line_class0),
        .line_class1 (line_class1),
        .queue_space (queue_space),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_class (instr_class),
        .instr_ready (instr_ready)
    );

endmodule

/* instr_queue.sv */
`timescale 1ns/10ps

module instr_queue import fetch_pkg::*; (
    input  logic       clk,
    input  logic       resetn,

    input  logic       flush,
    input  logic       enq_word0,
    input  logic       enq_word1,
    input  addr_t      enq_base,
    input  word_t      line_data0,
    input  word_t      line_data1,
    input  predecode_t line_class0,
    input  predecode_t line_class1,
    output qcount_t    queue_space,

    output logic       instr_valid,
    output word_t      instr,
    output addr_t      instr_pc,
    output predecode_t instr_class,
    input  logic       instr_ready
);

    word_t      q_word  [queue_depth];
    addr_t      q_pc    [queue_depth];
    predecode_t q_class [queue_depth];

    qptr_t   rd_ptr;
    qptr_t   wr_ptr;
    qptr_t   wr_ptr1;  // slot for word 1
    qcount_t count;
    logic    pop;

    assign instr_valid = (count != '0);
    assign pop         = instr_valid && instr_ready;
    assign queue_space = qcount_t'(queue_depth) - count;

    assign instr       = q_word[rd_ptr];
    assign instr_pc    = q_pc[rd_ptr];
    assign instr_class = q_class[rd_ptr];

    // word 1 lands right behind word 0 when both are written
    assign wr_ptr1 = wr_ptr + qptr_t'(enq_word0);

    always_ff @(posedge clk) begin
        if (enq_word0) begin
            q_word[wr_ptr]  <= line_data0;
            q_pc[wr_ptr]    <= enq_base;
            q_class[wr_ptr] <= line_class0;
        end
        if (enq_word1) begin
            q_word[wr_ptr1]  <= line_data1;
            q_pc[wr_ptr1]    <= enq_base + addr_t'(word_bytes);
            q_class[wr_ptr1] <= line_class1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            wr_ptr <= wr_ptr + qptr_t'(enq_word0) + qptr_t'(enq_word1);
            count  <= count + qcount_t'(enq_word0) + qcount_t'(enq_word1)
                      - qcount_t'(pop);
        end
    end

endmodule

/* predecoder.sv */
`timescale 1ns/10ps

module predecoder import fetch_pkg::*; (
    input  word_t      word,
    output predecode_t cls
);

    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [5:0] funct;
    logic       regimm_branch;
    logic       plain_branch;
    logic       ret_jump;

    assign opcode = word[31:26];
    assign rs     = word[25:21];
    assign rt     = word[20:16];
    assign funct  = word[5:0];

    always_comb begin
        unique case (rt)
            rt_bltz, rt_bgez, rt_bltzal, rt_bgezal: regimm_branch = (opcode == op_regimm);
            default:                                regimm_branch = 1'b0;
        endcase
    end

    always_comb begin
        unique case (opcode)
            op_beq, op_bne, op_blez, op_bgtz, op_j: plain_branch = 1'b1;
            op_special:                             plain_branch = (funct == funct_jalr);
            default:                                plain_branch = 1'b0;
        endcase
    end

    // jr ra only, other jr targets are plain indirect jumps
    assign ret_jump = (opcode == op_special) && (rs == reg_ra) && (funct == funct_jr);

    always_comb begin
        if (plain_branch || regimm_branch) begin
            cls = is_branch;
        end else if (ret_jump) begin
            cls = is_ret;
        end else if (opcode == op_jal) begin
            cls = is_call;
        end else begin
            cls = normal;
        end
    end

endmodule

/* tb.f */
fetch_pkg.sv
predecoder.sv
icache_fetch.sv
fetch_pc.sv
instr_queue.sv
ifetch_top.sv
tb_ifetch.sv

/* tb_ifetch.sv */
`timescale 1ns/10ps

module tb_ifetch import fetch_pkg::*; ();

    localparam int timeout_cycles = 200;
    localparam int stall_at       = 16;  // first pop after the last redirect
    localparam int stall_cycles   = 80;

    logic       clk;
    logic       resetn;
    logic       redirect;
    addr_t      redirect_pc;
    logic       mem_req;
    addr_t      mem_addr;
    logic       mem_ready;
    logic       mem_last;
    word_t      mem_rdata;
    logic       instr_valid;
    word_t      instr;
    addr_t      instr_pc;
    predecode_t instr_class;
    logic       instr_ready;

    addr_t      img_addr [$];
    word_t      img_data [$];
    predecode_t img_cls  [$];
    int         redir_idx [$];
    addr_t      redir_pc  [$];

    int    value_errors;
    int    other_errors;
    logic  abort;
    addr_t next_vaddr;    // line the memory expects next
    logic  redir_pend;
    addr_t redir_target;

    ifetch_top dut (
        .clk         (clk),
        .resetn      (resetn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ready   (mem_ready),
        .mem_last    (mem_last),
        .mem_rdata   (mem_rdata),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_class (instr_class),
        .instr_ready (instr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // kseg0 and kseg1 drop the top three bits
    function automatic addr_t xlate(input addr_t va);
        if (va[31] && !va[30]) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    function automatic int find_image(input addr_t pa);
        for (int i = 0; i < img_addr.size(); i++) begin
            if (img_addr[i] == pa) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic word_t read_image(input addr_t pa);
        int k;
        k = find_image(pa);
        if (k >= 0) begin
            return img_data[k];
        end
        return {pa[15:0], pa[31:16]} ^ 32'h5ca1_ab1e;  // filler outside the image
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_class(input string name, input predecode_t got,
                               input predecode_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(),
                     exp.name());
            value_errors++;
        end
    endtask

    task automatic fail_now(input string what);
        $display("%0t %s", $time, what);
        other_errors++;
        abort = 1'b1;
    endtask

    task automatic load_golden();
        int         fd;
        int         n;
        logic [63:0] tag;
        logic [31:0] a;
        logic [31:0] w;
        int          c;
        logic [8*160-1:0] rest;
        fd = $fopen("ifetch_golden.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open ifetch_golden.txt");
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "m") begin
                n = $fscanf(fd, "%h %h %d", a, w, c);
                if (n != 3) begin
                    fail_now("incomplete memory line in golden file");
                end
                img_addr.push_back(a);
                img_data.push_back(w);
                img_cls.push_back(predecode_t'(c[1:0]));
            end else if (tag == "r") begin
                n = $fscanf(fd, "%d %h", c, a);
                if (n != 2) begin
                    fail_now("incomplete redirect line in golden file");
                end
                redir_idx.push_back(c);
                redir_pc.push_back(a);
            end else if (tag == "#") begin
                n = $fgets(rest, fd);  // column notes
            end else begin
                fail_now("unknown line type in golden file");
            end
        end
        $fclose(fd);
    endtask

    task automatic serve_burst();
        addr_t exp;
        addr_t tgt;
        int    d;
        exp = xlate(next_vaddr) & 32'hffff_fff8;
        tgt = xlate(redir_target) & 32'hffff_fff8;
        if (mem_addr === exp) begin
            next_vaddr = next_vaddr + 32'd8;
        end else if (redir_pend && mem_addr === tgt) begin
            next_vaddr = {redir_target[31:3], 3'b000} + 32'd8;
            redir_pend = 1'b0;
        end else begin
            check_addr("mem_addr", mem_addr, exp);
        end
        for (int b = 0; b < line_words; b++) begin
            d = $urandom % 4;
            repeat (d) begin
                @(posedge clk);
                #10;
            end
            mem_ready = 1'b1;
            mem_rdata = read_image(mem_addr + 32'(4 * b));
            mem_last  = (b == line_words - 1);
            @(posedge clk);
            #10;
            mem_ready = 1'b0;
            mem_last  = 1'b0;
            if (b == 0 && !mem_req) begin
                fail_now("burst ended after the first beat");
            end
        end
        if (mem_req) begin
            fail_now("mem_req still high after the last beat");
        end
    endtask

    task automatic serve_memory();
        int cnt;
        while (!abort) begin
            cnt = 0;
            while (!mem_req && cnt < timeout_cycles && !abort) begin
                @(posedge clk);
                #10;
                cnt++;
            end
            if (mem_req) begin
                serve_burst();
            end else if (!abort) begin
                fail_now("no memory request within the timeout");
            end
        end
    endtask

    task automatic pop_check(input addr_t exp_pc);
        int    cnt;
        int    k;
        logic  done;
        cnt  = 0;
        done = 1'b0;
        k    = find_image(xlate(exp_pc));
        while (!done && cnt < timeout_cycles) begin
            instr_ready = ($urandom % 4) != 0;
            if (instr_valid && instr_ready) begin  // taken at the next edge
                check_addr("instr_pc", instr_pc, exp_pc);
                check_word("instr", instr, img_data[k]);
                check_class("instr_class", instr_class, img_cls[k]);
                done = 1'b1;
            end
            @(posedge clk);
            #10;
            cnt++;
        end
        instr_ready = 1'b0;
        if (!done) begin
            fail_now("no instruction reached decode within the timeout");
        end
    endtask

    task automatic wait_burst();
        int cnt;
        cnt = 0;
        while (!mem_req && cnt < timeout_cycles) begin
            @(posedge clk);
            #10;
            cnt++;
        end
        if (!mem_req) begin
            fail_now("no burst in flight to redirect into");
        end
    endtask

    task automatic send_redirect(input addr_t target);
        instr_ready  = 1'b0;
        redirect     = 1'b1;
        redirect_pc  = target;
        redir_target = target;
        redir_pend   = 1'b1;
        @(posedge clk);
        #10;
        redirect = 1'b0;
    endtask

    // decode stalls until the queue is full
    task automatic hold_decode();
        instr_ready = 1'b0;
        repeat (stall_cycles) begin
            @(posedge clk);
            #10;
        end
        if (mem_req) begin
            fail_now("fetch still running with a full queue");
        end
        if (!instr_valid) begin
            fail_now("queue empty after a decode stall");
        end
    endtask

    task automatic close_run();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        int    seed_val;
        addr_t exp_pc;
        int    idx;
        int    rptr;
        value_errors = 0;
        other_errors = 0;
        abort        = 1'b0;
        seed_val     = $urandom(32'h9a57);
        resetn       = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        mem_ready    = 1'b0;
        mem_last     = 1'b0;
        mem_rdata    = '0;
        instr_ready  = 1'b0;
        next_vaddr   = reset_pc;
        redir_pend   = 1'b0;
        redir_target = reset_pc;
        load_golden();
        repeat (5) @(posedge clk);
        #10;
        resetn = 1'b1;
        fork
            serve_memory();
        join_none
        exp_pc = reset_pc;
        idx    = 0;
        rptr   = 0;
        while (!abort && find_image(xlate(exp_pc)) >= 0) begin
            pop_check(exp_pc);
            idx++;
            exp_pc = exp_pc + 32'd4;
            if (idx == stall_at) begin
                hold_decode();
            end
            if (rptr < redir_idx.size() && idx == redir_idx[rptr]) begin
                if (rptr == 0) begin
                    wait_burst();  // first redirect lands on a live burst
                end
                send_redirect(redir_pc[rptr]);
                exp_pc = redir_pc[rptr];
                rptr++;
            end
        end
        if (!abort && rptr != redir_idx.size()) begin
            fail_now("instruction stream ended before all redirects");
        end
        close_run();
    end

endmodule
